// File: Makefile
VERILATOR ?= verilator
TOP ?= loadMissTb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '*** FAILED ***' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
source/loadMissPkg.sv
source/loadMissQueue.sv
source/lineFill.sv
source/uncachedReader.sv
source/memArbiter.sv
source/loadMissTop.sv
test/memoryModel.sv
test/loadMissTb.sv

// File: source/lineFill.sv
module lineFill (
    input logic clk,
    input logic rst,
    input logic fillReqValid,
    output logic fillReqReady,
    input loadMissPkg::lineAddr_t fillReqLine,
    output logic readValid,
    input logic readReady,
    output loadMissPkg::addr_t readAddr,
    input logic respValid,
    input loadMissPkg::word_t respData,
    output loadMissPkg::FillStatus fillStatus,
    output loadMissPkg::CacheWrite cacheWrite
);
    import loadMissPkg::*;

    FillState state;
    lineAddr_t lineReg;
    wordIdx_t wordCnt;
    progress_t progress;
    word_t dataReg;

    assign fillReqReady = (state == FILL_IDLE);
    assign readValid = (state == FILL_REQUEST);
    assign readAddr = {lineReg, wordCnt, 2'b00};

    always_comb begin
        fillStatus.active = (state != FILL_IDLE);
        fillStatus.line = lineReg;
        fillStatus.progress = progress;

        // One write per word, the cycle after its response
        cacheWrite.enable = (state == FILL_WRITE);
        cacheWrite.line = lineReg;
        cacheWrite.word = wordCnt;
        cacheWrite.data = dataReg;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILL_IDLE;
            wordCnt <= '0;
            progress <= '0;
        end else begin
            case (state)
                FILL_IDLE: begin
                    if (fillReqValid) begin
                        lineReg <= fillReqLine;
                        wordCnt <= '0;
                        progress <= '0;
                        state <= FILL_REQUEST;
                    end
                end
                FILL_REQUEST: begin
                    if (readReady)
                        state <= FILL_WAIT;
                end
                FILL_WAIT: begin
                    if (respValid) begin
                        dataReg <= respData;
                        // Word counts as filled while its write is presented
                        progress <= progress + 1'b1;
                        state <= FILL_WRITE;
                    end
                end
                FILL_WRITE: begin
                    wordCnt <= wordCnt + 1'b1;
                    // Last word ends the fill
                    state <= (wordCnt == wordIdx_t'(LINE_WORDS - 1)) ? FILL_IDLE : FILL_REQUEST;
                end
                default: state <= FILL_IDLE;
            endcase
        end
    end

endmodule

// File: source/loadMissPkg.sv
package loadMissPkg;

    localparam int ADDR_BITS = 32;
    localparam int LINE_OFFSET_BITS = 5;
    localparam int WORD_IDX_BITS = LINE_OFFSET_BITS - 2;
    localparam int LINE_WORDS = 1 << WORD_IDX_BITS;
    localparam int PROGRESS_BITS = 4;
    localparam int SQN_BITS = 6;
    localparam int WORD_BITS = 32;
    localparam int TAG_BITS = 4;
    localparam int QUEUE_SIZE = 4;
    localparam int QUEUE_IDX_BITS = $clog2(QUEUE_SIZE);
    // Read latency of the memory behind the arbiter
    localparam int MEM_LATENCY = 3;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [ADDR_BITS-LINE_OFFSET_BITS-1:0] lineAddr_t;
    typedef logic [WORD_IDX_BITS-1:0] wordIdx_t;
    typedef logic [PROGRESS_BITS-1:0] progress_t;
    typedef logic [SQN_BITS-1:0] sqn_t;
    typedef logic [WORD_BITS-1:0] word_t;

    typedef struct packed {
        addr_t addr;
        sqn_t sqN;
        logic external;
        logic [TAG_BITS-1:0] tag;
    } LoadOp;

    typedef struct packed {
        logic taken;
        sqn_t sqN;
    } BranchFlush;

    typedef struct packed {
        logic active;
        lineAddr_t line;
        progress_t progress;
    } FillStatus;

    typedef struct packed {
        logic enable;
        lineAddr_t line;
        wordIdx_t word;
        word_t data;
    } CacheWrite;

    typedef struct packed {
        addr_t addr;
    } MemReq;

    typedef struct packed {
        word_t data;
    } MemResp;

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_REQUEST,
        FILL_WAIT,
        FILL_WRITE
    } FillState;

    typedef enum logic [1:0] {
        READ_IDLE,
        READ_REQUEST,
        READ_WAIT,
        READ_RESPOND
    } ReadState;

endpackage

// File: source/loadMissQueue.sv
module loadMissQueue (
    input logic clk,
    input logic rst,
    input loadMissPkg::BranchFlush flush,
    input loadMissPkg::FillStatus fillStatus,
    input logic loadValid,
    output logic loadReady,
    input loadMissPkg::LoadOp load,
    input logic replayAny,
    output logic replayValid,
    input logic replayReady,
    output loadMissPkg::LoadOp replay,
    output logic queueBusy
);
    import loadMissPkg::*;

    typedef struct packed {
        logic valid;
        logic ready;
        LoadOp op;
    } QueueEntry;

    QueueEntry entries [QUEUE_SIZE];

    logic freeFound;
    logic [QUEUE_IDX_BITS-1:0] freeIdx;
    logic deqFound;
    logic [QUEUE_IDX_BITS-1:0] deqIdx;

    // Younger than the branch and not external
    function automatic logic isSquashed(LoadOp op, BranchFlush br);
        logic signed [SQN_BITS-1:0] age;
        age = op.sqN - br.sqN;
        return !op.external && br.taken && (age > 0);
    endfunction

    // Lowest free slot, lowest replay candidate
    always_comb begin
        freeFound = 1'b0;
        freeIdx = '0;
        deqFound = 1'b0;
        deqIdx = '0;
        queueBusy = 1'b0;
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            if (entries[i].valid)
                queueBusy = 1'b1;
            if (!freeFound && !entries[i].valid) begin
                freeFound = 1'b1;
                freeIdx = QUEUE_IDX_BITS'(i);
            end
            if (!deqFound && entries[i].valid && (entries[i].ready || replayAny) &&
                !isSquashed(entries[i].op, flush)) begin
                deqFound = 1'b1;
                deqIdx = QUEUE_IDX_BITS'(i);
            end
        end
    end

    assign loadReady = freeFound;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < QUEUE_SIZE; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].ready <= 1'b0;
            end
            replayValid <= 1'b0;
        end else begin
            for (int i = 0; i < QUEUE_SIZE; i++) begin
                // Fill has written past this entry's word
                if (entries[i].valid && fillStatus.active &&
                    entries[i].op.addr[ADDR_BITS-1:LINE_OFFSET_BITS] == fillStatus.line &&
                    progress_t'(entries[i].op.addr[LINE_OFFSET_BITS-1:2]) <
                    fillStatus.progress)
                    entries[i].ready <= 1'b1;
                if (isSquashed(entries[i].op, flush))
                    entries[i].valid <= 1'b0;
            end

            // Squashed on arrival means accepted and dropped
            if (loadValid && freeFound && !isSquashed(load, flush)) begin
                entries[freeIdx].valid <= 1'b1;
                entries[freeIdx].ready <= 1'b0;
                entries[freeIdx].op <= load;
            end

            if ((replayValid && replayReady) || isSquashed(replay, flush))
                replayValid <= 1'b0;
            if ((!replayValid || replayReady) && deqFound) begin
                replayValid <= 1'b1;
                replay <= entries[deqIdx].op;
                entries[deqIdx].valid <= 1'b0;
            end
        end
    end

endmodule

// File: source/loadMissTop.sv
module loadMissTop (
    input logic clk,
    input logic rst,
    input loadMissPkg::BranchFlush flush,
    input logic loadValid,
    output logic loadReady,
    input loadMissPkg::LoadOp load,
    input logic replayAny,
    output logic replayValid,
    input logic replayReady,
    output loadMissPkg::LoadOp replay,
    input logic fillReqValid,
    output logic fillReqReady,
    input loadMissPkg::lineAddr_t fillReqLine,
    input logic ucReqValid,
    output logic ucReqReady,
    input loadMissPkg::addr_t ucReqAddr,
    output logic ucRespValid,
    output loadMissPkg::word_t ucRespData,
    output logic memReqValid,
    input logic memReqReady,
    output loadMissPkg::MemReq memReq,
    input logic memRespValid,
    input loadMissPkg::MemResp memResp,
    output loadMissPkg::FillStatus fillStatus,
    output loadMissPkg::CacheWrite cacheWrite,
    output logic queueBusy
);
    import loadMissPkg::*;

    // Master 0 is the line fill, master 1 the uncached reader
    logic [1:0] readValid;
    logic [1:0] readReady;
    addr_t fillReadAddr;
    addr_t ucReadAddr;
    logic fillRespValid;
    logic ucMemRespValid;
    word_t respData;

    loadMissQueue queue0 (
        .clk(clk), .rst(rst), .flush(flush), .fillStatus(fillStatus),
        .loadValid(loadValid), .loadReady(loadReady), .load(load),
        .replayAny(replayAny), .replayValid(replayValid), .replayReady(replayReady),
        .replay(replay), .queueBusy(queueBusy)
    );

    lineFill fill0 (
        .clk(clk), .rst(rst),
        .fillReqValid(fillReqValid), .fillReqReady(fillReqReady), .fillReqLine(fillReqLine),
        .readValid(readValid[0]), .readReady(readReady[0]), .readAddr(fillReadAddr),
        .respValid(fillRespValid), .respData(respData),
        .fillStatus(fillStatus), .cacheWrite(cacheWrite)
    );

    uncachedReader reader0 (
        .clk(clk), .rst(rst),
        .ucReqValid(ucReqValid), .ucReqReady(ucReqReady), .ucReqAddr(ucReqAddr),
        .readValid(readValid[1]), .readReady(readReady[1]), .readAddr(ucReadAddr),
        .respValid(ucMemRespValid), .respData(respData),
        .ucRespValid(ucRespValid), .ucRespData(ucRespData)
    );

    memArbiter arbiter0 (
        .clk(clk), .rst(rst),
        .reqValid(readValid), .reqReady(readReady),
        .reqAddr0(fillReadAddr), .reqAddr1(ucReadAddr),
        .respValid0(fillRespValid), .respValid1(ucMemRespValid), .respData(respData),
        .memReqValid(memReqValid), .memReqReady(memReqReady), .memReq(memReq),
        .memRespValid(memRespValid), .memResp(memResp)
    );

endmodule

// File: source/memArbiter.sv
module memArbiter (
    input logic clk,
    input logic rst,
    input logic [1:0] reqValid,
    output logic [1:0] reqReady,
    input loadMissPkg::addr_t reqAddr0,
    input loadMissPkg::addr_t reqAddr1,
    output logic respValid0,
    output logic respValid1,
    output loadMissPkg::word_t respData,
    output logic memReqValid,
    input logic memReqReady,
    output loadMissPkg::MemReq memReq,
    input logic memRespValid,
    input loadMissPkg::MemResp memResp
);

    logic busy;
    logic owner;
    logic favored;
    logic grantIdx;

    always_comb begin
        // Favored master first, otherwise the other one
        grantIdx = reqValid[favored] ? favored : !favored;
        memReqValid = !busy && (|reqValid);
        memReq.addr = grantIdx ? reqAddr1 : reqAddr0;
        reqReady = 2'b00;
        if (!busy && memReqReady && reqValid[grantIdx])
            reqReady[grantIdx] = 1'b1;

        respValid0 = memRespValid && busy && !owner;
        respValid1 = memRespValid && busy && owner;
        respData = memResp.data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            owner <= 1'b0;
            favored <= 1'b0;
        end else if (!busy) begin
            if (memReqValid && memReqReady) begin
                busy <= 1'b1;
                owner <= grantIdx;
                favored <= !grantIdx;
            end
        end else if (memRespValid) begin
            busy <= 1'b0;
        end
    end

endmodule

// File: source/uncachedReader.sv
module uncachedReader (
    input logic clk,
    input logic rst,
    input logic ucReqValid,
    output logic ucReqReady,
    input loadMissPkg::addr_t ucReqAddr,
    output logic readValid,
    input logic readReady,
    output loadMissPkg::addr_t readAddr,
    input logic respValid,
    input loadMissPkg::word_t respData,
    output logic ucRespValid,
    output loadMissPkg::word_t ucRespData
);
    import loadMissPkg::*;

    ReadState state;
    addr_t addrReg;
    word_t dataReg;

    assign ucReqReady = (state == READ_IDLE);
    assign readValid = (state == READ_REQUEST);
    assign readAddr = addrReg;
    assign ucRespValid = (state == READ_RESPOND);
    assign ucRespData = dataReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= READ_IDLE;
        end else begin
            case (state)
                READ_IDLE: begin
                    if (ucReqValid) begin
                        addrReg <= ucReqAddr;
                        state <= READ_REQUEST;
                    end
                end
                // Hold the request until the arbiter takes it
                READ_REQUEST: if (readReady) state <= READ_WAIT;
                READ_WAIT: begin
                    if (respValid) begin
                        dataReg <= respData;
                        state <= READ_RESPOND;
                    end
                end
                default: state <= READ_IDLE;
            endcase
        end
    end

endmodule

// File: test/loadMissTb.sv
module loadMissTb;
    import loadMissPkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TAGS = 1 << TAG_BITS;
    localparam int NUM_LOADS = 10;
    localparam int NUM_FILLS = 3;
    localparam int NUM_UC_READS = 3;
    localparam int NUM_OPS = NUM_FILLS * LINE_WORDS + NUM_LOADS + NUM_UC_READS;
    // Arbitration against the other engine can double a read
    localparam int OP_CYCLES = 8 * (MEM_LATENCY + 4);
    localparam int DRAIN_CYCLES = 4 * QUEUE_SIZE + 8;
    localparam int TIMEOUT = (NUM_OPS * OP_CYCLES + 4 * DRAIN_CYCLES) * CLK_PERIOD;
    localparam lineAddr_t LINE_A = 27'h0123456;
    localparam lineAddr_t LINE_B = 27'h0345678;
    localparam lineAddr_t LINE_C = 27'h0567ABC;
    // Never filled
    localparam lineAddr_t LINE_D = 27'h07F0F0F;

    logic clk;
    logic rst;
    BranchFlush flush;
    logic loadValid;
    logic loadReady;
    LoadOp load;
    logic replayAny;
    logic replayValid;
    logic replayReady;
    LoadOp replay;
    logic fillReqValid;
    logic fillReqReady;
    lineAddr_t fillReqLine;
    logic ucReqValid;
    logic ucReqReady;
    addr_t ucReqAddr;
    logic ucRespValid;
    word_t ucRespData;
    logic memReqValid;
    logic memReqReady;
    MemReq memReq;
    logic memRespValid;
    MemResp memResp;
    FillStatus fillStatus;
    CacheWrite cacheWrite;
    logic queueBusy;

    logic [31:0] lfsrState = 32'd98641;
    logic stallOn = 1'b0;
    int errors = 0;
    int checks = 0;

    // Per tag bookkeeping of every offered load
    logic accepted [NUM_TAGS];
    logic killed [NUM_TAGS];
    logic early [NUM_TAGS];
    int replayCount [NUM_TAGS];
    LoadOp ops [NUM_TAGS];

    lineAddr_t fillLine = '0;
    int writeCount = 0;
    logic [LINE_WORDS-1:0] writtenMask = '0;
    addr_t ucPending [$];
    logic prevStalled = 1'b0;
    LoadOp prevReplay;

    loadMissTop dut0 (
        .clk(clk), .rst(rst), .flush(flush),
        .loadValid(loadValid), .loadReady(loadReady), .load(load),
        .replayAny(replayAny), .replayValid(replayValid), .replayReady(replayReady),
        .replay(replay),
        .fillReqValid(fillReqValid), .fillReqReady(fillReqReady), .fillReqLine(fillReqLine),
        .ucReqValid(ucReqValid), .ucReqReady(ucReqReady), .ucReqAddr(ucReqAddr),
        .ucRespValid(ucRespValid), .ucRespData(ucRespData),
        .memReqValid(memReqValid), .memReqReady(memReqReady), .memReq(memReq),
        .memRespValid(memRespValid), .memResp(memResp),
        .fillStatus(fillStatus), .cacheWrite(cacheWrite), .queueBusy(queueBusy)
    );

    memoryModel memory0 (
        .clk(clk), .rst(rst),
        .memReqValid(memReqValid), .memReqReady(memReqReady), .memReq(memReq),
        .memRespValid(memRespValid), .memResp(memResp)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
    endtask

    function automatic word_t memWord(addr_t a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
    endfunction

    // Younger means a positive difference in SQN_BITS two's complement
    function automatic logic squashed(LoadOp op, BranchFlush br);
        sqn_t diff;
        diff = op.sqN - br.sqN;
        return br.taken && !op.external && !diff[SQN_BITS-1] && (diff != '0);
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Random replay stalls
    initial begin : stallDriver
        logic [31:0] bits;
        replayReady = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (stallOn) begin
                drawBits(1, bits);
                replayReady = bits[0];
            end else begin
                replayReady = 1'b1;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT);
        $display("ERROR: watchdog expired after %0d time units before the run ended", TIMEOUT);
        $display("checks=%0d errors=%0d", checks, errors + 1);
        $display("*** FAILED ***");
        $finish;
    end

    // Outputs are sampled mid-cycle, handshakes complete on the next rising edge
    always @(negedge clk) begin : compare
        int t;
        addr_t ucAddr;
        if (!rst) begin
            if (replayValid && replayReady) begin
                t = int'(replay.tag);
                checks++;
                if (!accepted[t]) begin
                    errors++;
                    $display("Replay of tag %0d, which was never accepted", t);
                end else if (killed[t]) begin
                    errors++;
                    $display("Squashed load tag %0d was replayed", t);
                end else if (replayCount[t] != 0) begin
                    errors++;
                    $display("Load tag %0d was replayed a second time", t);
                end else if (replay != ops[t]) begin
                    errors++;
                    $display("FAIL replay: got %h expected %h", replay, ops[t]);
                end else if (!early[t] &&
                    !(ops[t].addr[ADDR_BITS-1:LINE_OFFSET_BITS] == fillLine &&
                      writtenMask[ops[t].addr[LINE_OFFSET_BITS-1:2]])) begin
                    errors++;
                    $display("Load tag %0d replayed before the cache write of its word", t);
                end
                replayCount[t]++;
            end

            // A stalled replay must not change
            if (prevStalled && replayValid) begin
                checks++;
                if (replay != prevReplay) begin
                    errors++;
                    $display("FAIL replay: got %h expected %h", replay, prevReplay);
                end
            end
            prevStalled = replayValid && !replayReady;
            prevReplay = replay;

            if (loadValid && loadReady) begin
                t = int'(load.tag);
                accepted[t] = 1'b1;
                ops[t] = load;
                early[t] = replayAny;
            end
            for (int i = 0; i < NUM_TAGS; i++) begin
                if (accepted[i] && replayCount[i] == 0 && !killed[i]) begin
                    if (squashed(ops[i], flush))
                        killed[i] = 1'b1;
                    if (replayAny)
                        early[i] = 1'b1;
                end
            end

            if (fillReqValid && fillReqReady) begin
                fillLine = fillReqLine;
                writeCount = 0;
                writtenMask = '0;
            end
            if (cacheWrite.enable) begin
                checks++;
                if (cacheWrite.line != fillLine) begin
                    errors++;
                    $display("FAIL cacheWrite.line: got %h expected %h", cacheWrite.line, fillLine);
                end
                if (cacheWrite.word != wordIdx_t'(writeCount)) begin
                    errors++;
                    $display("FAIL cacheWrite.word: got %h expected %h",
                        cacheWrite.word, wordIdx_t'(writeCount));
                end
                if (cacheWrite.data != memWord({fillLine, wordIdx_t'(writeCount), 2'b00})) begin
                    errors++;
                    $display("FAIL cacheWrite.data: got %h expected %h", cacheWrite.data,
                        memWord({fillLine, wordIdx_t'(writeCount), 2'b00}));
                end
                writtenMask[cacheWrite.word] = 1'b1;
                writeCount++;
            end

            if (ucReqValid && ucReqReady)
                ucPending.push_back(ucReqAddr);
            if (ucRespValid) begin
                checks++;
                if (ucPending.size() == 0) begin
                    errors++;
                    $display("Uncached response arrived without a pending request");
                end else begin
                    ucAddr = ucPending.pop_front();
                    if (ucRespData != memWord(ucAddr)) begin
                        errors++;
                        $display("FAIL ucRespData: got %h expected %h",
                            ucRespData, memWord(ucAddr));
                    end
                end
            end
        end
    end

    // Tasks start and end a short delay after a rising edge
    task automatic pickAddr(input lineAddr_t line, output addr_t a);
        logic [31:0] bits;
        drawBits(WORD_IDX_BITS, bits);
        a = {line, bits[WORD_IDX_BITS-1:0], 2'b00};
    endtask

    task automatic sendLoad(input addr_t a, input sqn_t sqN, input logic ext, input int tag,
                            input BranchFlush br);
        loadValid = 1'b1;
        load = '{addr: a, sqN: sqN, external: ext, tag: TAG_BITS'(tag)};
        flush = br;
        @(negedge clk);
        while (!loadReady)
            @(negedge clk);
        @(posedge clk);
        #2;
        loadValid = 1'b0;
        flush = '0;
    endtask

    task automatic requestFill(input lineAddr_t line);
        fillReqValid = 1'b1;
        fillReqLine = line;
        @(negedge clk);
        while (!fillReqReady)
            @(negedge clk);
        @(posedge clk);
        #2;
        fillReqValid = 1'b0;
    endtask

    task automatic finishFill();
        @(negedge clk);
        while (fillStatus.active || !fillReqReady)
            @(negedge clk);
        checks++;
        if (fillStatus.progress != progress_t'(LINE_WORDS)) begin
            errors++;
            $display("FAIL fillStatus.progress: got %h expected %h",
                fillStatus.progress, progress_t'(LINE_WORDS));
        end
        checks++;
        if (fillStatus.line != fillLine) begin
            errors++;
            $display("FAIL fillStatus.line: got %h expected %h", fillStatus.line, fillLine);
        end
        checks++;
        if (writeCount != LINE_WORDS) begin
            errors++;
            $display("Fill wrote %0d words instead of %0d", writeCount, LINE_WORDS);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic waitQueueEmpty();
        @(negedge clk);
        while (queueBusy || replayValid)
            @(negedge clk);
        @(posedge clk);
        #2;
    endtask

    task automatic ucRead(input addr_t a);
        ucReqValid = 1'b1;
        ucReqAddr = a;
        @(negedge clk);
        while (!ucReqReady)
            @(negedge clk);
        @(posedge clk);
        #2;
        ucReqValid = 1'b0;
    endtask

    task automatic waitUcDone();
        @(posedge clk);
        while (ucPending.size() != 0)
            @(posedge clk);
        #2;
    endtask

    initial begin : stimulus
        addr_t a;
        logic [31:0] bits;
        flush = '0;
        loadValid = 1'b0;
        load = '0;
        replayAny = 1'b0;
        fillReqValid = 1'b0;
        fillReqLine = '0;
        ucReqValid = 1'b0;
        ucReqAddr = '0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            accepted[i] = 1'b0;
            killed[i] = 1'b0;
            early[i] = 1'b0;
            replayCount[i] = 0;
            ops[i] = '0;
        end
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        checks++;
        if (replayValid || fillStatus.active || cacheWrite.enable || memReqValid ||
            ucRespValid || !loadReady || !fillReqReady) begin
            errors++;
            $display("Outputs after reset are not at their idle values");
        end
        stallOn = 1'b1;
        @(posedge clk);
        #2;

        // Four loads wait on line A until its fill
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            pickAddr(LINE_A, a);
            sendLoad(a, sqn_t'(i), 1'b0, i, '0);
        end
        @(negedge clk);
        checks++;
        if (loadReady || !queueBusy) begin
            errors++;
            $display("Full queue still takes loads or does not report busy");
        end
        @(posedge clk);
        #2;
        requestFill(LINE_A);
        finishFill();
        waitQueueEmpty();

        // Branch at sqN 15, one load wraps around and counts as older
        pickAddr(LINE_B, a);
        sendLoad(a, 6'd62, 1'b0, 4, '0);
        pickAddr(LINE_B, a);
        sendLoad(a, 6'd20, 1'b1, 5, '0);
        pickAddr(LINE_B, a);
        sendLoad(a, 6'd40, 1'b0, 6, '0);
        pickAddr(LINE_B, a);
        sendLoad(a, 6'd30, 1'b0, 7, BranchFlush'{taken: 1'b1, sqN: 6'd15});
        requestFill(LINE_B);
        finishFill();
        waitQueueEmpty();

        // Uncached reads compete with the fill of line C
        requestFill(LINE_C);
        for (int i = 0; i < NUM_UC_READS; i++) begin
            drawBits(ADDR_BITS - 2, bits);
            ucRead({bits[ADDR_BITS-3:0], 2'b00});
        end
        waitUcDone();
        finishFill();

        // Early replay of loads whose line is never filled
        replayAny = 1'b1;
        pickAddr(LINE_D, a);
        sendLoad(a, 6'd50, 1'b0, 8, '0);
        pickAddr(LINE_D, a);
        sendLoad(a, 6'd51, 1'b1, 9, '0);
        waitQueueEmpty();
        replayAny = 1'b0;
        stallOn = 1'b0;
        repeat (4) @(posedge clk);

        for (int i = 0; i < NUM_TAGS; i++) begin
            if (accepted[i] && !killed[i]) begin
                checks++;
                if (replayCount[i] != 1) begin
                    errors++;
                    $display("Load tag %0d replayed %0d times instead of once",
                        i, replayCount[i]);
                end
            end
        end
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: test/memoryModel.sv
module memoryModel (
    input logic clk,
    input logic rst,
    input logic memReqValid,
    output logic memReqReady,
    input loadMissPkg::MemReq memReq,
    output logic memRespValid,
    output loadMissPkg::MemResp memResp
);
    import loadMissPkg::*;

    logic [MEM_LATENCY-1:0] validPipe;
    word_t dataPipe [MEM_LATENCY];

    // Every address bit feeds the data word
    function automatic word_t mixAddress(addr_t a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
    endfunction

    // Only one read is ever in flight, so never stall
    assign memReqReady = 1'b1;
    assign memRespValid = validPipe[MEM_LATENCY-1];
    assign memResp.data = dataPipe[MEM_LATENCY-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[MEM_LATENCY-2:0], memReqValid && memReqReady};
        end
        // Data travels beside its valid bit
        dataPipe[0] <= mixAddress(memReq.addr);
        for (int i = 1; i < MEM_LATENCY; i++)
            dataPipe[i] <= dataPipe[i-1];
    end

endmodule
